// File: verilog/zx_mem_pkg.sv
`default_nettype none

package zx_mem_pkg;

	// ==================================================================
	// Memory map constants
	// ==================================================================

	// Flat RAM address in 16K banks
	localparam int RAM_ADDR_W    = 25;
	localparam int BANK_BITS     = 14;

	// First ROM bank sits above all RAM banks
	localparam int ROM_BANK_BASE = 80;

	// ==================================================================
	// Encodings
	// ==================================================================

	// Machine models numbered as in the core status word
	typedef enum logic [2:0] {
		MACHINE_128K      = 3'd0,
		MACHINE_P1024     = 3'd1,
		MACHINE_PROFI1024 = 3'd2,
		MACHINE_48K       = 3'd3,
		MACHINE_PLUS3     = 3'd4
	} machine_t;

	// Paging port opcodes
	typedef enum logic [2:0] {
		OP_NONE = 3'd0,
		OP_7FFD = 3'd1,
		OP_1FFD = 3'd2,
		OP_DFFD = 3'd3,
		OP_EFF7 = 3'd4
	} port_op_t;

	// ==================================================================
	// Bundles
	// ==================================================================

	// CPU bus with active-high strobes
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// One decoded port write
	typedef struct packed {
		port_op_t    op;
		logic [7:0]  data;
	} page_cmd_t;

	// Complete paging state
	typedef struct packed {
		machine_t    model;
		logic [7:0]  reg_7ffd;
		logic [7:0]  reg_1ffd;
		logic [7:0]  reg_eff7;
		// Upper bits of the slot 3 bank on 1024K machines
		logic [2:0]  page_ext;
	} paging_t;

	// Request to the RAM controller
	typedef struct packed {
		logic [RAM_ADDR_W-1:0] addr;
		logic                  rd;
		logic                  we;
	} ram_req_t;

endpackage

`default_nettype wire

// File: verilog/zx_port_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module zx_port_decoder (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire zx_mem_pkg::cpu_bus_t bus,
	input  wire zx_mem_pkg::machine_t model,
	output zx_mem_pkg::page_cmd_t cmd
);

	// ==================================================================
	// I/O write edge
	// ==================================================================

	logic io_wr;
	logic io_wr_d;
	logic io_edge;

	// M1 with IORQ is an interrupt acknowledge, not a write
	assign io_wr   = bus.iorq & bus.wr & ~bus.m1;
	assign io_edge = io_wr & ~io_wr_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
		end
	end

	// ==================================================================
	// Port address classification
	// ==================================================================

	logic is_plus3;
	logic is_profi;
	logic is_p1024;

	assign is_plus3 = (model == zx_mem_pkg::MACHINE_PLUS3);
	assign is_profi = (model == zx_mem_pkg::MACHINE_PROFI1024);
	assign is_p1024 = (model == zx_mem_pkg::MACHINE_P1024);

	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_dffd;
	logic sel_eff7;

	// +3 decodes A14 as well, to free room for 1FFD
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & (bus.addr[14] | ~is_plus3);
	assign sel_1ffd = ~bus.addr[15] & ~bus.addr[14] & ~bus.addr[13] & bus.addr[12] &
		~bus.addr[1] & is_plus3;
	assign sel_dffd = (bus.addr == 16'hDFFD) & is_profi;
	assign sel_eff7 = bus.addr[15] & bus.addr[14] & bus.addr[13] & ~bus.addr[12] &
		~bus.addr[3] & is_p1024;

	zx_mem_pkg::port_op_t op_next;

	always_comb begin
		op_next = zx_mem_pkg::OP_NONE;
		if (io_edge) begin
			if (sel_7ffd) begin
				op_next = zx_mem_pkg::OP_7FFD;
			end else if (sel_1ffd) begin
				op_next = zx_mem_pkg::OP_1FFD;
			end else if (sel_dffd) begin
				op_next = zx_mem_pkg::OP_DFFD;
			end else if (sel_eff7) begin
				op_next = zx_mem_pkg::OP_EFF7;
			end
		end
	end

	// Command register with its data byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd.op <= zx_mem_pkg::OP_NONE;
		end else begin
			cmd.op <= op_next;
		end
		cmd.data <= bus.dout;
	end

	// A command lasts a single cycle
	assert property (@(posedge clk_sys) disable iff (reset)
		(cmd.op != zx_mem_pkg::OP_NONE) |=> (cmd.op == zx_mem_pkg::OP_NONE))
		else $error("paging command held for two cycles");

endmodule

`default_nettype wire

// File: verilog/zx_paging_registers.sv
`timescale 1ns/10ps
`default_nettype none

module zx_paging_registers (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire zx_mem_pkg::machine_t  model,
	input  wire zx_mem_pkg::page_cmd_t cmd,
	output zx_mem_pkg::paging_t    paging
);

	// ==================================================================
	// Model flags
	// ==================================================================

	logic is_48k;
	logic is_p1024;
	logic is_profi;

	// Taken from the latched model, not the live input
	assign is_48k   = (paging.model == zx_mem_pkg::MACHINE_48K);
	assign is_p1024 = (paging.model == zx_mem_pkg::MACHINE_P1024);
	assign is_profi = (paging.model == zx_mem_pkg::MACHINE_PROFI1024);

	logic ext_mem;

	assign ext_mem = is_p1024 | is_profi;

	// ==================================================================
	// Paging lock
	// ==================================================================

	logic locked;
	logic eff7_lock_mode;

	// Pentagon only honours bit 5 once EFF7 bit 2 selects 128K mode
	assign eff7_lock_mode = paging.reg_eff7[2];

	always_comb begin
		locked = 1'b0;
		if (is_48k) begin
			locked = 1'b1;
		end else if (is_p1024) begin
			locked = eff7_lock_mode & paging.reg_7ffd[5];
		end else begin
			locked = paging.reg_7ffd[5];
		end
	end

	// ==================================================================
	// Register updates
	// ==================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			paging.model    <= model;
			paging.reg_7ffd <= 8'h00;
			paging.reg_1ffd <= 8'h00;
			paging.reg_eff7 <= 8'h00;
			paging.page_ext <= 3'b000;
		end else begin
			case (cmd.op)
				zx_mem_pkg::OP_7FFD: begin
					if (!locked) begin
						paging.reg_7ffd <= cmd.data;
						// 1024K extension bits in 5,7,6 order
						if (is_p1024 && !eff7_lock_mode) begin
							paging.page_ext <= {cmd.data[5], cmd.data[7:6]};
						end
					end
				end
				zx_mem_pkg::OP_1FFD: begin
					if (!locked) begin
						paging.reg_1ffd <= cmd.data;
					end
				end
				zx_mem_pkg::OP_DFFD: begin
					// Profi extension ignores the lock
					paging.page_ext <= cmd.data[2:0];
				end
				zx_mem_pkg::OP_EFF7: begin
					paging.reg_eff7 <= cmd.data;
				end
				default: begin
				end
			endcase
		end
	end

	// ==================================================================
	// Checks
	// ==================================================================

	// Decoder must not pass extension commands to 128K machines
	assert property (@(posedge clk_sys) disable iff (reset)
		!ext_mem |-> (paging.page_ext == 3'b000))
		else $error("page_ext set on a model without extended memory");

endmodule

`default_nettype wire

// File: verilog/zx_address_mapper.sv
`timescale 1ns/10ps
`default_nettype none

module zx_address_mapper (
	input  wire zx_mem_pkg::cpu_bus_t bus,
	input  wire zx_mem_pkg::paging_t  paging,
	output zx_mem_pkg::ram_req_t  ram
);

	localparam int BANK_W = zx_mem_pkg::RAM_ADDR_W - zx_mem_pkg::BANK_BITS;

	// ==================================================================
	// Slot and mode
	// ==================================================================

	logic [1:0] slot;
	logic       special;
	logic [1:0] special_cfg;

	assign slot        = bus.addr[15:14];
	assign special     = paging.reg_1ffd[0];
	assign special_cfg = paging.reg_1ffd[2:1];

	// ==================================================================
	// ROM select
	// ==================================================================

	logic [3:0] rom_num;

	always_comb begin
		case (paging.model)
			zx_mem_pkg::MACHINE_PLUS3: rom_num = {2'b10, paging.reg_1ffd[2], paging.reg_7ffd[4]};
			zx_mem_pkg::MACHINE_48K:   rom_num = 4'd15;
			default:                   rom_num = {3'b011, paging.reg_7ffd[4]};
		endcase
	end

	// ==================================================================
	// Bank select
	// ==================================================================

	logic [2:0]        special_bank;
	logic [BANK_W-1:0] bank;

	// +3 all-RAM configurations
	always_comb begin
		case (special_cfg)
			2'b00: special_bank = {1'b0, slot};
			2'b01: special_bank = {1'b1, slot};
			2'b10: special_bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};
			default: begin
				case (slot)
					2'd0:    special_bank = 3'd4;
					2'd1:    special_bank = 3'd7;
					2'd2:    special_bank = 3'd6;
					default: special_bank = 3'd3;
				endcase
			end
		endcase
	end

	always_comb begin
		if (special) begin
			bank = BANK_W'(special_bank);
		end else begin
			case (slot)
				2'd0:    bank = BANK_W'(zx_mem_pkg::ROM_BANK_BASE) + BANK_W'(rom_num);
				2'd1:    bank = BANK_W'(5);
				2'd2:    bank = BANK_W'(2);
				default: bank = BANK_W'({paging.page_ext, paging.reg_7ffd[2:0]});
			endcase
		end
	end

	// ==================================================================
	// Request
	// ==================================================================

	logic rom_slot;

	// ROM only appears in slot 0 outside special mode
	assign rom_slot = ~special & (slot == 2'd0);

	always_comb begin
		ram.addr = {bank, bus.addr[zx_mem_pkg::BANK_BITS-1:0]};
		ram.rd   = bus.mreq & bus.rd;
		ram.we   = bus.mreq & bus.wr & ~rom_slot;
	end

	// Writes must stay below the ROM area
	always_comb begin
		if (ram.we) begin
			assert (ram.addr[zx_mem_pkg::RAM_ADDR_W-1:zx_mem_pkg::BANK_BITS] <
				BANK_W'(zx_mem_pkg::ROM_BANK_BASE))
				else $error("RAM write strobe on a ROM bank");
		end
	end

endmodule

`default_nettype wire

// File: verilog/zx_memory_map.sv
`timescale 1ns/10ps
`default_nettype none

module zx_memory_map (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire zx_mem_pkg::cpu_bus_t bus,
	input  wire zx_mem_pkg::machine_t model,
	output zx_mem_pkg::ram_req_t  ram,
	output zx_mem_pkg::paging_t   paging,
	output logic                  page_scr
);

	// ==================================================================
	// Decode stage
	// ==================================================================

	zx_mem_pkg::page_cmd_t cmd;

	// Decoder follows the latched model
	zx_port_decoder u_port_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.model   (paging.model),
		.cmd     (cmd)
	);

	// ==================================================================
	// Register stage
	// ==================================================================

	zx_paging_registers u_paging_registers (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.cmd     (cmd),
		.paging  (paging)
	);

	// ==================================================================
	// Address stage
	// ==================================================================

	zx_address_mapper u_address_mapper (
		.bus    (bus),
		.paging (paging),
		.ram    (ram)
	);

	// Shadow screen select for the video side
	assign page_scr = paging.reg_7ffd[3];

endmodule

`default_nettype wire

// File: sim/tb_zx_tasks.svh
`ifndef TB_ZX_TASKS_SVH
`define TB_ZX_TASKS_SVH

// ======================================================================
// Reference model
// ======================================================================

// +3 all-RAM banks indexed by {1ffd bits 2..1, slot}
localparam int SPECIAL_BANKS [16] = '{0, 1, 2, 3, 4, 5, 6, 7, 4, 5, 6, 3, 4, 7, 6, 3};

// Which paging port a write hits on the given model
function automatic zx_mem_pkg::port_op_t port_of(input logic [15:0] a,
		input zx_mem_pkg::machine_t m);
	if (!a[15] && !a[1] && (a[14] || m != zx_mem_pkg::MACHINE_PLUS3)) begin
		return zx_mem_pkg::OP_7FFD;
	end
	if (a[15:12] == 4'b0001 && !a[1] && m == zx_mem_pkg::MACHINE_PLUS3) begin
		return zx_mem_pkg::OP_1FFD;
	end
	if (a == 16'hDFFD && m == zx_mem_pkg::MACHINE_PROFI1024) begin
		return zx_mem_pkg::OP_DFFD;
	end
	if (a[15:12] == 4'b1110 && !a[3] && m == zx_mem_pkg::MACHINE_P1024) begin
		return zx_mem_pkg::OP_EFF7;
	end
	return zx_mem_pkg::OP_NONE;
endfunction

function automatic zx_mem_pkg::paging_t after_port_write(input zx_mem_pkg::paging_t s,
		input logic [15:0] a, input logic [7:0] d);
	logic p1024;
	logic locked;
	p1024  = (s.model == zx_mem_pkg::MACHINE_P1024);
	locked = (s.model == zx_mem_pkg::MACHINE_48K) ||
		(s.reg_7ffd[5] && (!p1024 || s.reg_eff7[2]));
	case (port_of(a, s.model))
		zx_mem_pkg::OP_7FFD: begin
			if (!locked) begin
				// Pentagon takes three more bank bits from the same byte
				if (p1024 && !s.reg_eff7[2]) begin
					s.page_ext = {d[5], d[7], d[6]};
				end
				s.reg_7ffd = d;
			end
		end
		zx_mem_pkg::OP_1FFD: begin
			if (!locked) begin
				s.reg_1ffd = d;
			end
		end
		zx_mem_pkg::OP_DFFD: s.page_ext = d[2:0];
		zx_mem_pkg::OP_EFF7: s.reg_eff7 = d;
		default: begin
		end
	endcase
	return s;
endfunction

function automatic logic [24:0] expected_addr(input logic [15:0] a,
		input zx_mem_pkg::paging_t s);
	int bank;
	int rom;
	if (s.model == zx_mem_pkg::MACHINE_PLUS3) begin
		rom = 8 + 2 * int'(s.reg_1ffd[2]) + int'(s.reg_7ffd[4]);
	end else if (s.model == zx_mem_pkg::MACHINE_48K) begin
		rom = 15;
	end else begin
		rom = 6 + int'(s.reg_7ffd[4]);
	end
	if (s.reg_1ffd[0]) begin
		bank = SPECIAL_BANKS[{s.reg_1ffd[2:1], a[15:14]}];
	end else begin
		case (a[15:14])
			2'd0:    bank = zx_mem_pkg::ROM_BANK_BASE + rom;
			2'd1:    bank = 5;
			2'd2:    bank = 2;
			default: bank = 8 * int'(s.page_ext) + int'(s.reg_7ffd[2:0]);
		endcase
	end
	return {11'(bank), a[13:0]};
endfunction

// ROM sits in slot 0 only outside the all-RAM mode
function automatic logic expected_we(input zx_mem_pkg::cpu_bus_t b,
		input zx_mem_pkg::paging_t s);
	return b.mreq && b.wr && (s.reg_1ffd[0] || b.addr[15:14] != 2'd0);
endfunction

// ======================================================================
// Bus cycles
// ======================================================================

task automatic apply_reset(input zx_mem_pkg::machine_t m);
	@(negedge clk_sys);
	reset        = 1'b1;
	model        = m;
	bus          = '0;
	shadow       = '0;
	shadow.model = m;
	repeat (3) @(negedge clk_sys);
	reset = 1'b0;
endtask

// One memory cycle, then the strobes drop for a cycle
task automatic mem_cycle(input logic [15:0] a, input logic [7:0] d,
		input logic mreq, input logic rd, input logic wr);
	@(negedge clk_sys);
	bus.addr = a;
	bus.dout = d;
	bus.mreq = mreq;
	bus.rd   = rd;
	bus.wr   = wr;
	@(negedge clk_sys);
	bus.mreq = 1'b0;
	bus.rd   = 1'b0;
	bus.wr   = 1'b0;
endtask

// I/O write with the expected state moving two edges later
task automatic io_write(input logic [15:0] a, input logic [7:0] d);
	@(negedge clk_sys);
	write_busy = 1'b1;
	bus.addr   = a;
	bus.dout   = d;
	bus.iorq   = 1'b1;
	bus.wr     = 1'b1;
	@(posedge clk_sys);
	@(negedge clk_sys);
	bus.iorq = 1'b0;
	bus.wr   = 1'b0;
	@(posedge clk_sys);
	shadow = after_port_write(shadow, a, d);
	@(negedge clk_sys);
	write_busy = 1'b0;
endtask

// Random reads and writes in every slot
task automatic sweep_slots(input int n);
	int          s;
	int          i;
	logic [15:0] a;
	for (s = 0; s < 4; s++) begin
		for (i = 0; i < n; i++) begin
			a = {2'(s), 14'($urandom)};
			mem_cycle(a, 8'h00, 1'b1, 1'b1, 1'b0);
			mem_cycle(a, 8'($urandom), 1'b1, 1'b0, 1'b1);
		end
	end
endtask

`endif

// File: sim/tb_zx_memory_map.sv
`timescale 1ns/10ps
`default_nettype none

module tb_zx_memory_map;

	localparam int CLK_PERIOD = 40;
	localparam int N_TESTS    = 6;

	logic                 clk_sys;
	logic                 reset;
	zx_mem_pkg::cpu_bus_t bus;
	zx_mem_pkg::machine_t model;
	zx_mem_pkg::ram_req_t ram;
	zx_mem_pkg::paging_t  paging;
	logic                 page_scr;

	// Expected paging state
	zx_mem_pkg::paging_t  shadow;
	logic                 write_busy;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int errors_at_start = 0;

	zx_memory_map u_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus),
		.model    (model),
		.ram      (ram),
		.paging   (paging),
		.page_scr (page_scr)
	);

	`include "tb_zx_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_sys = ~clk_sys;
		end
	end

	initial begin
		repeat (N_TESTS * 2000) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d clock cycles", N_TESTS * 2000);
		$display("Errors found");
		$finish;
	end

	// ==================================================================
	// Checks
	// ==================================================================

	task automatic report_mismatch(input string what);
		errors = errors + 1;
		$display("MISMATCH at %0t: %s", $time, what);
	endtask

	assert property (@(posedge clk_sys) disable iff (reset)
		bus.mreq |-> (ram.addr == expected_addr(bus.addr, shadow)))
		else report_mismatch($sformatf("ram.addr %h for cpu address %h", ram.addr, bus.addr));

	assert property (@(posedge clk_sys) disable iff (reset)
		bus.mreq |-> (ram.rd == bus.rd))
		else report_mismatch("ram.rd does not follow mreq and rd");

	assert property (@(posedge clk_sys) disable iff (reset)
		bus.mreq |-> (ram.we == expected_we(bus, shadow)))
		else report_mismatch($sformatf("ram.we wrong for cpu address %h", bus.addr));

	assert property (@(posedge clk_sys) disable iff (reset)
		!bus.mreq |-> (!ram.rd && !ram.we))
		else report_mismatch("RAM strobe without mreq");

	assert property (@(posedge clk_sys) disable iff (reset || write_busy)
		(paging == shadow) && (page_scr == shadow.reg_7ffd[3]))
		else report_mismatch($sformatf("paging %h, expected %h", paging, shadow));

	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		if (errors == errors_at_start) begin
			$display("Test %0d %s: pass", tests_run, name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("Test %0d %s: FAIL, %0d mismatches", tests_run, name,
				errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// ==================================================================
	// Tests
	// ==================================================================

	task automatic reset_defaults_all_models();
		zx_mem_pkg::machine_t m;
		m = m.first();
		repeat (m.num()) begin
			apply_reset(m);
			sweep_slots(2);
			m = m.next();
		end
	endtask

	task automatic paging_and_lock_128k();
		int i;
		apply_reset(zx_mem_pkg::MACHINE_128K);
		// Partial decode accepts any address with A15 and A1 low
		for (i = 0; i < 8; i++) begin
			io_write(16'h7FFD & 16'($urandom), (8'($urandom) & 8'hD8) | 8'(i));
			sweep_slots(1);
		end
		io_write(16'h7FFD, 8'h2B);
		for (i = 0; i < 4; i++) begin
			io_write(16'h7FFD, 8'($urandom));
			sweep_slots(1);
		end
	endtask

	task automatic special_modes_plus3();
		int i;
		apply_reset(zx_mem_pkg::MACHINE_PLUS3);
		for (i = 0; i < 4; i++) begin
			io_write(16'h1FFD, 8'(2 * i + 1));
			sweep_slots(1);
		end
		for (i = 0; i < 4; i++) begin
			io_write(16'h1FFD, 8'((i / 2) * 4));
			io_write(16'h7FFD, 8'((i % 2) * 16));
			sweep_slots(1);
		end
		io_write(16'h3FFD, 8'h07);
		io_write(16'h7FFD, 8'h20);
		io_write(16'h1FFD, 8'h01);
		sweep_slots(1);
	endtask

	task automatic bank_extension_1024k();
		int i;
		apply_reset(zx_mem_pkg::MACHINE_P1024);
		for (i = 0; i < 6; i++) begin
			io_write(16'h7FFD, 8'($urandom));
			sweep_slots(1);
		end
		io_write(16'hEFF7, 8'h04);
		for (i = 0; i < 3; i++) begin
			io_write(16'h7FFD, 8'($urandom));
			sweep_slots(1);
		end
		apply_reset(zx_mem_pkg::MACHINE_PROFI1024);
		for (i = 0; i < 4; i++) begin
			io_write(16'hDFFD, 8'($urandom));
			io_write(16'h7FFD, 8'($urandom) & 8'hDF);
			sweep_slots(1);
		end
	endtask

	task automatic write_strobe_gating();
		apply_reset(zx_mem_pkg::MACHINE_PLUS3);
		sweep_slots(2);
		mem_cycle(16'h0123, 8'h00, 1'b1, 1'b0, 1'b0);
		mem_cycle(16'h4123, 8'h00, 1'b0, 1'b1, 1'b0);
		mem_cycle(16'h0123, 8'h55, 1'b0, 1'b0, 1'b1);
		io_write(16'h1FFD, 8'h01);
		sweep_slots(2);
	endtask

	task automatic port_writes_48k();
		apply_reset(zx_mem_pkg::MACHINE_48K);
		repeat (2) begin
			io_write(16'h7FFD, 8'($urandom));
			io_write(16'h1FFD, 8'($urandom));
			io_write(16'hDFFD, 8'($urandom));
			io_write(16'hEFF7, 8'($urandom));
			sweep_slots(1);
		end
	endtask

	initial begin
		void'($urandom(32'h4d95));
		reset      = 1'b1;
		model      = zx_mem_pkg::MACHINE_128K;
		bus        = '0;
		shadow     = '0;
		write_busy = 1'b0;
		reset_defaults_all_models();
		end_test("reset defaults");
		paging_and_lock_128k();
		end_test("128K paging and lock");
		special_modes_plus3();
		end_test("+3 paging");
		bank_extension_1024k();
		end_test("1024K extension");
		write_strobe_gating();
		end_test("write strobes");
		port_writes_48k();
		end_test("48K ports");
		$display("Tests: %0d run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+sim
verilog/zx_mem_pkg.sv
verilog/zx_port_decoder.sv
verilog/zx_paging_registers.sv
verilog/zx_address_mapper.sv
verilog/zx_memory_map.sv
sim/tb_zx_memory_map.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_zx_memory_map

obj_dir/Vtb_zx_memory_map: vlog.f verilog/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f vlog.f --top-module tb_zx_memory_map

# Pass only when the testbench prints its pass line
run: compile
	@out="$$(./obj_dir/Vtb_zx_memory_map)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
